// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_rv_core
FILELIST   := files.f
OBJ_DIR    := obj_dir
LOG        := sim.log
FLAGS      := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing --assert
FAIL_MSG   := TEST RESULT: FAIL
PASS_MSG   := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "no result line in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== files.f ====
+incdir+.
rv_isa_pkg.sv
rv_ctrl_pkg.sv
rv_decode_if.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_lsu.sv
rv_core.sv
tb_rv_core.sv

// ==== rv_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_alu
  import rv_isa_pkg::*, rv_ctrl_pkg::*;
(
  input  alu_op_e op,
  input  word_t   a,
  input  word_t   b,
  output word_t   result,
  input  branch_e branch,
  output logic    taken
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign shamt = b[4:0];   // rv32 shifts use five bits
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;

  always_comb begin
    case (op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_sll:    result = a << shamt;
      alu_slt:    result = {31'b0, lt_s};
      alu_sltu:   result = {31'b0, lt_u};
      alu_xor:    result = a ^ b;
      alu_srl:    result = a >> shamt;
      alu_sra:    result = word_t'($signed(a) >>> shamt);
      alu_or:     result = a | b;
      alu_and:    result = a & b;
      alu_pass_b: result = b;
      default:    result = a + b;
    endcase
  end

  // branch compare runs on rs1 and rs2
  always_comb begin
    case (branch)
      br_eq:   taken = (a == b);
      br_ne:   taken = (a != b);
      br_lt:   taken = lt_s;
      br_ge:   taken = !lt_s;
      br_ltu:  taken = lt_u;
      br_geu:  taken = !lt_u;
      br_jal,
      br_jalr: taken = 1'b1;
      default: taken = 1'b0;   // br_none
    endcase
  end

endmodule

`default_nettype wire

// ==== rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core
  import rv_isa_pkg::*, rv_ctrl_pkg::*;
#(
  parameter word_t RESET_PC = '0,
  parameter int    NUM_REGS = 32
) (
  input  logic     clk,
  input  logic     rst,
  output word_t    pc,
  input  word_t    insn,
  output word_t    dmem_addr,
  input  word_t    load_data,
  output word_t    store_data,
  output byte_en_t store_we,
  output logic     halt
);

  rv_decode_if dec_if ();

  word_t rs1_data;
  word_t rs2_data;
  word_t alu_a;
  word_t alu_b;
  word_t alu_result;
  word_t load_result;
  word_t pc_plus4;
  word_t pc_next;
  word_t rd_data;
  logic  taken;

  rv_decoder i_rv_decoder (
    .insn (insn),
    .dec  (dec_if.decoder)
  );

  rv_regfile #(
    .NUM_REGS (NUM_REGS)
  ) i_rv_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1      (dec_if.rs1),
    .rs2      (dec_if.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rd       (dec_if.rd),
    .rd_data  (rd_data),
    .we       (dec_if.reg_we)
  );

  assign alu_a = dec_if.alu_a_pc ? pc : rs1_data;
  assign alu_b = dec_if.alu_src_imm ? dec_if.imm : rs2_data;

  rv_alu i_rv_alu (
    .op     (dec_if.alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result),
    .branch (dec_if.branch),
    .taken  (taken)
  );

  rv_lsu i_rv_lsu (
    .dec         (dec_if.exec),
    .base        (rs1_data),
    .rs2_data    (rs2_data),
    .dmem_addr   (dmem_addr),
    .store_data  (store_data),
    .store_we    (store_we),
    .load_data   (load_data),
    .load_result (load_result)
  );

  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    pc_next = pc_plus4;
    if (taken) begin
      if (dec_if.branch == br_jalr) begin
        pc_next = {alu_result[31:1], 1'b0};   // rs1 + imm, bit 0 dropped
      end else begin
        pc_next = pc + dec_if.imm;   // branches and jal
      end
    end
  end

  always_comb begin
    case (dec_if.wb_sel)
      wb_load:     rd_data = load_result;
      wb_pc_plus4: rd_data = pc_plus4;   // link value
      default:     rd_data = alu_result;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  assign halt = dec_if.halt;

  // every taken target seen so far kept fetch word aligned
  pc_aligned_a: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("rv_core: misaligned pc %h", pc);

endmodule

`default_nettype wire

// ==== rv_ctrl_pkg.sv ====
`default_nettype none

package rv_ctrl_pkg;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b    // lui passes the immediate through
  } alu_op_e;

  // register writeback source
  typedef enum logic [1:0] {wb_alu, wb_load, wb_pc_plus4} wb_sel_e;

  // next-pc condition, evaluated in the alu
  typedef enum logic [3:0] {
    br_none, br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu, br_jal, br_jalr
  } branch_e;

  typedef enum logic [1:0] {mem_byte, mem_half, mem_word} mem_size_e;

endpackage

`default_nettype wire

// ==== rv_decode_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one decoded instruction, valid for the current cycle
interface rv_decode_if
  import rv_isa_pkg::*, rv_ctrl_pkg::*;
();

  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  word_t     imm;           // sign-extended, format picked by opcode
  alu_op_e   alu_op;
  logic      alu_src_imm;   // operand b is imm instead of rs2
  logic      alu_a_pc;      // operand a is pc (auipc)
  logic      reg_we;        // already low for rd == x0
  wb_sel_e   wb_sel;
  branch_e   branch;
  mem_size_e mem_size;
  logic      mem_unsigned;
  logic      mem_store;
  logic      halt;

  modport decoder (output rs1, rs2, rd, imm, alu_op, alu_src_imm, alu_a_pc, reg_we,
                   wb_sel, branch, mem_size, mem_unsigned, mem_store, halt);
  modport exec (input rs1, rs2, rd, imm, alu_op, alu_src_imm, alu_a_pc, reg_we,
                wb_sel, branch, mem_size, mem_unsigned, mem_store, halt);

endinterface

`default_nettype wire

// ==== rv_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_decoder
  import rv_isa_pkg::*, rv_ctrl_pkg::*;
(
  input  word_t         insn,
  rv_decode_if.decoder  dec
);

  opcode_t   opcode;
  funct3_t   funct3;
  funct7_t   funct7;
  reg_addr_t rd;
  word_t     imm_i;
  word_t     imm_s;
  word_t     imm_b;
  word_t     imm_j;
  word_t     imm_u;
  logic      writes_rd;
  logic      illegal;   // unknown encoding, runs as a no-op

  // shared by register-immediate and register-register forms
  function automatic alu_op_e alu_from_funct3(funct3_t f3, logic alt);
    alu_op_e op;
    case (f3)
      f3_add:  op = alt ? alu_sub : alu_add;
      f3_sll:  op = alu_sll;
      f3_slt:  op = alu_slt;
      f3_sltu: op = alu_sltu;
      f3_xor:  op = alu_xor;
      f3_sr:   op = alt ? alu_sra : alu_srl;
      f3_or:   op = alu_or;
      f3_and:  op = alu_and;
      default: op = alu_add;
    endcase
    return op;
  endfunction

  assign opcode  = insn[6:0];
  assign funct3  = insn[14:12];
  assign funct7  = insn[31:25];
  assign rd      = insn[11:7];
  assign dec.rd  = rd;
  assign dec.rs1 = insn[19:15];
  assign dec.rs2 = insn[24:20];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'h000};

  always_comb begin
    dec.imm          = imm_i;
    dec.alu_op       = alu_add;
    dec.alu_src_imm  = 1'b0;
    dec.alu_a_pc     = 1'b0;
    dec.wb_sel       = wb_alu;
    dec.branch       = br_none;
    dec.mem_size     = mem_word;
    dec.mem_unsigned = 1'b0;
    dec.mem_store    = 1'b0;
    dec.halt         = 1'b0;
    writes_rd        = 1'b0;
    illegal          = 1'b0;

    case (opcode)
      op_lui: begin
        dec.imm         = imm_u;
        dec.alu_op      = alu_pass_b;
        dec.alu_src_imm = 1'b1;
        writes_rd       = 1'b1;
      end
      op_auipc: begin
        dec.imm         = imm_u;
        dec.alu_a_pc    = 1'b1;
        dec.alu_src_imm = 1'b1;
        writes_rd       = 1'b1;
      end
      op_jal: begin
        dec.imm    = imm_j;
        dec.branch = br_jal;
        dec.wb_sel = wb_pc_plus4;
        writes_rd  = 1'b1;
      end
      op_jalr: begin
        dec.alu_src_imm = 1'b1;   // alu sum is the target
        dec.branch      = br_jalr;
        dec.wb_sel      = wb_pc_plus4;
        writes_rd       = 1'b1;
      end
      op_branch: begin
        dec.imm = imm_b;
        case (funct3)
          f3_beq:  dec.branch = br_eq;
          f3_bne:  dec.branch = br_ne;
          f3_blt:  dec.branch = br_lt;
          f3_bge:  dec.branch = br_ge;
          f3_bltu: dec.branch = br_ltu;
          f3_bgeu: dec.branch = br_geu;
          default: illegal = 1'b1;
        endcase
      end
      op_load: begin
        dec.wb_sel       = wb_load;
        dec.mem_unsigned = funct3[2];   // lbu, lhu
        writes_rd        = 1'b1;
        case (funct3[1:0])
          2'b00:   dec.mem_size = mem_byte;
          2'b01:   dec.mem_size = mem_half;
          2'b10:   dec.mem_size = mem_word;
          default: illegal = 1'b1;
        endcase
        if (funct3[2] && funct3[1]) begin
          illegal = 1'b1;   // no lwu in rv32
        end
      end
      op_store: begin
        dec.imm       = imm_s;
        dec.mem_store = 1'b1;
        case (funct3)
          3'b000:  dec.mem_size = mem_byte;
          3'b001:  dec.mem_size = mem_half;
          3'b010:  dec.mem_size = mem_word;
          default: begin
            dec.mem_store = 1'b0;
            illegal       = 1'b1;
          end
        endcase
      end
      op_reg_imm: begin
        dec.alu_src_imm = 1'b1;
        dec.alu_op      = alu_from_funct3(funct3, funct3 == f3_sr && funct7 == funct7_alt);
        writes_rd       = 1'b1;
      end
      op_reg_reg: begin
        dec.alu_op = alu_from_funct3(funct3, funct7 == funct7_alt);
        writes_rd  = 1'b1;
        if (funct7 != '0 && funct7 != funct7_alt) begin
          illegal = 1'b1;   // M extension and friends
        end
      end
      op_misc_mem: begin
        // fence, nothing to order in a single-cycle core
      end
      op_environ: dec.halt = (insn[31:7] == '0);   // ecall only
      default:    illegal = 1'b1;
    endcase
  end

  assign dec.reg_we = writes_rd && !illegal && (rd != '0);

  always_comb begin
    unsupported_insn_a: assert final ($isunknown(insn) || !illegal)
      else $warning("rv_decoder: unsupported instruction %h", insn);
  end

endmodule

`default_nettype wire

// ==== rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

  typedef logic [31:0] word_t;      // data, address or instruction word
  typedef logic [4:0]  reg_addr_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;
  typedef logic [3:0]  byte_en_t;   // one enable per byte lane

  // major opcodes, insn[6:0]
  localparam opcode_t op_lui      = 7'b0110111;
  localparam opcode_t op_auipc    = 7'b0010111;
  localparam opcode_t op_jal      = 7'b1101111;
  localparam opcode_t op_jalr     = 7'b1100111;
  localparam opcode_t op_branch   = 7'b1100011;
  localparam opcode_t op_load     = 7'b0000011;
  localparam opcode_t op_store    = 7'b0100011;
  localparam opcode_t op_reg_imm  = 7'b0010011;
  localparam opcode_t op_reg_reg  = 7'b0110011;
  localparam opcode_t op_misc_mem = 7'b0001111;
  localparam opcode_t op_environ  = 7'b1110011;

  localparam funct7_t funct7_alt = 7'b0100000;  // sub, sra, srai

  // arithmetic funct3
  localparam funct3_t f3_add  = 3'b000;   // add, sub, addi
  localparam funct3_t f3_sll  = 3'b001;
  localparam funct3_t f3_slt  = 3'b010;
  localparam funct3_t f3_sltu = 3'b011;
  localparam funct3_t f3_xor  = 3'b100;
  localparam funct3_t f3_sr   = 3'b101;   // srl, sra and immediate forms
  localparam funct3_t f3_or   = 3'b110;
  localparam funct3_t f3_and  = 3'b111;

  // branch funct3
  localparam funct3_t f3_beq  = 3'b000;
  localparam funct3_t f3_bne  = 3'b001;
  localparam funct3_t f3_blt  = 3'b100;
  localparam funct3_t f3_bge  = 3'b101;
  localparam funct3_t f3_bltu = 3'b110;
  localparam funct3_t f3_bgeu = 3'b111;

endpackage

`default_nettype wire

// ==== rv_lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_lsu
  import rv_isa_pkg::*, rv_ctrl_pkg::*;
(
  rv_decode_if.exec dec,
  input  word_t     base,
  input  word_t     rs2_data,
  output word_t     dmem_addr,
  output word_t     store_data,
  output byte_en_t  store_we,
  input  word_t     load_data,
  output word_t     load_result
);

  word_t      addr;         // byte address
  logic [4:0] lane_shift;   // bit offset of the addressed lane
  word_t      lane;         // addressed bytes moved down to bit 0
  logic       is_access;
  logic       misaligned;

  assign addr      = base + dec.imm;
  assign dmem_addr = {addr[31:2], 2'b00};

  always_comb begin
    case (dec.mem_size)
      mem_byte: lane_shift = {addr[1:0], 3'b000};
      mem_half: lane_shift = {addr[1], 4'b0000};
      default:  lane_shift = 5'd0;
    endcase
  end

  always_comb begin
    store_data = '0;
    store_we   = '0;
    if (dec.mem_store) begin
      case (dec.mem_size)
        mem_byte: begin
          store_data = word_t'(rs2_data[7:0]) << lane_shift;
          store_we   = 4'b0001 << addr[1:0];
        end
        mem_half: begin
          store_data = word_t'(rs2_data[15:0]) << lane_shift;
          store_we   = addr[1] ? 4'b1100 : 4'b0011;
        end
        default: begin
          store_data = rs2_data;
          store_we   = 4'b1111;
        end
      endcase
    end
  end

  assign lane = load_data >> lane_shift;

  always_comb begin
    case (dec.mem_size)
      mem_byte: load_result = dec.mem_unsigned ? {24'b0, lane[7:0]} : {{24{lane[7]}}, lane[7:0]};
      mem_half: load_result = dec.mem_unsigned ? {16'b0, lane[15:0]} : {{16{lane[15]}}, lane[15:0]};
      default:  load_result = load_data;
    endcase
  end

  assign is_access  = dec.mem_store || (dec.wb_sel == wb_load);
  assign misaligned = (dec.mem_size == mem_half && addr[0]) ||
                      (dec.mem_size == mem_word && addr[1:0] != 2'b00);

  always_comb begin
    natural_align_a: assert final ($isunknown({is_access, misaligned}) || !(is_access && misaligned))
      else $error("rv_lsu: misaligned access at %h", addr);
  end

endmodule

`default_nettype wire

// ==== rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_regfile
  import rv_isa_pkg::*;
#(
  parameter int NUM_REGS = 32
) (
  input  logic      clk,
  input  logic      rst,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  output word_t     rs1_data,
  output word_t     rs2_data,
  input  reg_addr_t rd,
  input  word_t     rd_data,
  input  logic      we
);

  localparam int idx_w = $clog2(NUM_REGS);

  word_t regs [NUM_REGS];

  // x0 is hardwired
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1[idx_w-1:0]];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2[idx_w-1:0]];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd[idx_w-1:0]] <= rd_data;
    end
  end

  // decoder must not target registers this file does not have
  rd_in_range_a: assert property (@(posedge clk) disable iff (rst) we |-> rd < NUM_REGS)
    else $error("rv_regfile: write to x%0d with only %0d registers", rd, NUM_REGS);

endmodule

`default_nettype wire

// ==== tb_rv_programs.svh ====
`ifndef TB_RV_PROGRAMS_SVH
`define TB_RV_PROGRAMS_SVH

// encoders, fields in isa order
function automatic word_t enc_r(funct7_t f7, reg_addr_t rs2, reg_addr_t rs1, funct3_t f3,
                                reg_addr_t rd, opcode_t op);
  return {f7, rs2, rs1, f3, rd, op};
endfunction

function automatic word_t enc_i(logic [11:0] imm, reg_addr_t rs1, funct3_t f3,
                                reg_addr_t rd, opcode_t op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic word_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1, funct3_t f3);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
endfunction

function automatic word_t enc_b(logic [12:0] off, reg_addr_t rs2, reg_addr_t rs1, funct3_t f3);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
endfunction

function automatic word_t enc_u(logic [19:0] imm, reg_addr_t rd, opcode_t op);
  return {imm, rd, op};
endfunction

function automatic word_t enc_j(logic [20:0] off, reg_addr_t rd);
  return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
endfunction

// place one instruction and the pc that must follow it
task automatic emit_to(word_t insn_word, word_t next);
  imem[asm_pc]     = insn_word;
  next_exp[asm_pc] = next;
  asm_pc           = asm_pc + 4;
endtask

task automatic emit(word_t insn_word);
  emit_to(insn_word, asm_pc + 4);
endtask

task automatic load_const(reg_addr_t rd, word_t value);
  word_t hi;
  hi = value + 32'h800;   // addi sign-extends the low part
  emit(enc_u(hi[31:12], rd, op_lui));
  emit(enc_i(value[11:0], rd, f3_add, rd, op_reg_imm));
  model[rd] = value;
endtask

task automatic expect_store(word_t addr, byte_en_t be, word_t data);
  exp_addr_q.push_back(addr);
  exp_be_q.push_back(be);
  exp_data_q.push_back(data);
endtask

// sw into the next result slot, x1 holds data_base
task automatic store_reg(reg_addr_t rs);
  emit(enc_s(slot_off[11:0], rs, 5'd1, 3'b010));
  expect_store(data_base + slot_off, 4'b1111, model[rs]);
  slot_off = slot_off + 4;
endtask

task automatic build_program();
  funct3_t     br_f3 [6];
  funct3_t     f3;
  word_t       a;
  word_t       b;
  word_t       v;
  word_t       p;
  logic [11:0] imm;
  logic [11:0] off;
  logic [7:0]  lanes [4];
  logic [15:0] halves [2];
  logic        t;

  br_f3    = '{f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu};
  asm_pc   = reset_pc;
  slot_off = '0;
  for (int r = 0; r < 32; r++) begin
    model[r] = '0;
  end
  load_const(5'd1, data_base);

  // upper immediates
  v = $urandom();
  emit(enc_u(v[31:12], 5'd5, op_lui));
  model[5] = {v[31:12], 12'h000};
  store_reg(5'd5);
  p = asm_pc;
  emit(enc_u(v[19:0], 5'd5, op_auipc));
  model[5] = p + {v[19:0], 12'h000};
  store_reg(5'd5);

  for (int f = 0; f < 8; f++) begin
    f3  = f[2:0];
    v   = $urandom();
    imm = v[11:0];
    if (f3 == f3_sll || f3 == f3_sr) begin
      imm = {7'b0, imm[4:0]};   // shamt only
    end
    load_const(5'd6, $urandom());
    emit(enc_i(imm, 5'd6, f3, 5'd7, op_reg_imm));
    model[7] = op_result(f3, 1'b0, model[6], sext12(imm));
    store_reg(5'd7);
    if (f3 == f3_sr) begin   // srai
      emit(enc_i({funct7_alt, imm[4:0]}, 5'd6, f3, 5'd7, op_reg_imm));
      model[7] = op_result(f3, 1'b1, model[6], {27'b0, imm[4:0]});
      store_reg(5'd7);
    end
  end

  // upper half of f runs the funct7_alt forms, sub and sra
  for (int f = 0; f < 16; f++) begin
    f3 = f[2:0];
    if (f >= 8 && f3 != f3_add && f3 != f3_sr) begin
      continue;
    end
    load_const(5'd6, $urandom());
    load_const(5'd8, $urandom());
    emit(enc_r(f >= 8 ? funct7_alt : 7'b0, 5'd8, 5'd6, f3, 5'd7, op_reg_reg));
    model[7] = op_result(f3, f >= 8, model[6], model[8]);
    store_reg(5'd7);
  end

  for (int k = 0; k < 4; k++) begin
    v        = $urandom();
    v[7]     = k[0];   // alternate the sign bit
    lanes[k] = v[7:0];
    off      = 12'h700 + k[11:0];
    load_const(5'd6, v);
    emit(enc_s(off, 5'd6, 5'd1, 3'b000));
    expect_store(data_base + 32'h700, byte_en_t'(1 << k), word_t'(v[7:0]) << (8 * k));
  end
  for (int h = 0; h < 2; h++) begin
    v         = $urandom();
    v[15]     = !h[0];
    halves[h] = v[15:0];
    off       = h[0] ? 12'h706 : 12'h704;
    load_const(5'd6, v);
    emit(enc_s(off, 5'd6, 5'd1, 3'b001));
    expect_store(data_base + 32'h704, h[0] ? 4'b1100 : 4'b0011,
                 word_t'(v[15:0]) << (16 * h));
  end

  // reload what the byte and half stores left
  for (int k = 0; k < 4; k++) begin
    off = 12'h700 + k[11:0];
    emit(enc_i(off, 5'd1, 3'b000, 5'd7, op_load));   // lb
    model[7] = {{24{lanes[k][7]}}, lanes[k]};
    store_reg(5'd7);
    emit(enc_i(off, 5'd1, 3'b100, 5'd7, op_load));   // lbu
    model[7] = {24'h0, lanes[k]};
    store_reg(5'd7);
  end
  for (int h = 0; h < 2; h++) begin
    off = h[0] ? 12'h706 : 12'h704;
    emit(enc_i(off, 5'd1, 3'b001, 5'd7, op_load));   // lh
    model[7] = {{16{halves[h][15]}}, halves[h]};
    store_reg(5'd7);
    emit(enc_i(off, 5'd1, 3'b101, 5'd7, op_load));   // lhu
    model[7] = {16'h0, halves[h]};
    store_reg(5'd7);
  end
  emit(enc_i(12'h700, 5'd1, 3'b010, 5'd7, op_load));   // lw
  model[7] = {lanes[3], lanes[2], lanes[1], lanes[0]};
  store_reg(5'd7);

  // each condition sees equal, signed-low and signed-high operands
  for (int c = 0; c < 18; c++) begin
    a = $urandom();
    b = $urandom();
    case (c % 3)
      0: b = a;
      1: begin
        a[31] = 1'b1;
        b[31] = 1'b0;
      end
      default: begin
        a[31] = 1'b0;
        b[31] = 1'b1;
      end
    endcase
    f3 = br_f3[c / 3];
    t  = branch_rule(f3, a, b);
    load_const(5'd8, a);
    load_const(5'd9, b);
    emit_to(enc_b(13'd8, 5'd9, 5'd8, f3), t ? asm_pc + 8 : asm_pc + 4);
    emit(enc_i(12'd1, 5'd10, f3_add, 5'd10, op_reg_imm));   // skipped when taken
  end

  // jal forward, back, then past the landing
  p = asm_pc;
  emit_to(enc_j(21'd12, 5'd14), p + 12);
  emit_to(enc_j(21'd12, 5'd0), p + 16);
  emit(enc_i(12'd1, 5'd10, f3_add, 5'd10, op_reg_imm));   // never reached
  emit_to(enc_j(21'h1ffff8, 5'd15), p + 4);   // -8
  model[14] = p + 4;
  model[15] = p + 16;
  store_reg(5'd14);
  store_reg(5'd15);

  p = asm_pc + 8;
  load_const(5'd12, p + 9);   // odd sum, bit 0 goes
  emit_to(enc_i(12'd4, 5'd12, 3'b000, 5'd13, op_jalr), p + 12);
  emit(enc_i(12'd1, 5'd10, f3_add, 5'd10, op_reg_imm));
  emit(enc_i(12'd1, 5'd10, f3_add, 5'd10, op_reg_imm));
  model[13] = p + 4;
  store_reg(5'd13);

  v = $urandom();
  emit(enc_i(v[11:0] | 12'h001, 5'd0, f3_add, 5'd0, op_reg_imm));   // write to x0
  store_reg(5'd0);

  emit(enc_i(12'h0ff, 5'd0, 3'b000, 5'd0, op_misc_mem));   // fence
  emit(ecall_insn);
  prog_len = int'(asm_pc - reset_pc) / 4;
endtask

`endif

// ==== tb_rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core
  import rv_isa_pkg::*;
();

  localparam word_t reset_pc   = 32'h0000_0000;
  localparam word_t data_base  = 32'h0000_1000;
  localparam word_t ecall_insn = 32'h0000_0073;

  logic     clk = 1'b0;
  logic     rst = 1'b1;
  word_t    pc;
  word_t    insn = '0;
  word_t    dmem_addr;
  word_t    load_data = '0;
  word_t    store_data;
  byte_en_t store_we;
  logic     halt;

  word_t    imem [word_t];
  word_t    dmem [word_t];
  word_t    next_exp [word_t];   // pc that must follow each program address
  word_t    model [32];          // register values known while assembling
  word_t    exp_addr_q [$];
  byte_en_t exp_be_q [$];
  word_t    exp_data_q [$];
  word_t    asm_pc;
  word_t    slot_off;
  word_t    want_pc;
  int       prog_len = 0;
  int       mem_gen = 0;
  int       cycles = 0;
  int       limit = 0;
  int       errors = 0;
  int       checks = 0;
  logic     done = 1'b0;
  logic     first = 1'b1;

  function automatic word_t sext12(logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // rv32i arithmetic rules
  function automatic word_t op_result(funct3_t f3, logic alt, word_t a, word_t b);
    logic [4:0] s;
    s = b[4:0];
    case (f3)
      f3_add:  return alt ? a - b : a + b;
      f3_sll:  return a << s;
      f3_slt:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
      f3_sltu: return {31'b0, a < b};
      f3_xor:  return a ^ b;
      f3_sr:   return (alt && a[31]) ? ~(~a >> s) : a >> s;
      f3_or:   return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_rule(funct3_t f3, word_t a, word_t b);
    logic lt_u;
    logic lt_s;
    lt_u = a < b;
    lt_s = (a[31] != b[31]) ? a[31] : lt_u;
    case (f3)
      f3_beq:  return a == b;
      f3_bne:  return a != b;
      f3_blt:  return lt_s;
      f3_bge:  return !lt_s;
      f3_bltu: return lt_u;
      default: return !lt_u;
    endcase
  endfunction

  `include "tb_rv_programs.svh"

  function automatic word_t fill_word(word_t a);
    return {a[15:0], ~a[31:16]} ^ 32'h6c8e_9a35;
  endfunction

  function automatic word_t fetch(word_t a);
    return imem.exists(a) ? imem[a] : fill_word(a);
  endfunction

  function automatic word_t read_data(word_t a);
    return dmem.exists(a) ? dmem[a] : fill_word(a);
  endfunction

  function automatic word_t merge_bytes(word_t old, word_t data, byte_en_t be);
    word_t w;
    w = old;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) w[8*i +: 8] = data[8*i +: 8];
    end
    return w;
  endfunction

  rv_core #(
    .RESET_PC (reset_pc),
    .NUM_REGS (32)
  ) i_rv_core (
    .clk        (clk),
    .rst        (rst),
    .pc         (pc),
    .insn       (insn),
    .dmem_addr  (dmem_addr),
    .load_data  (load_data),
    .store_data (store_data),
    .store_we   (store_we),
    .halt       (halt)
  );

  initial begin
    forever #10 clk = ~clk;
  end

  // combinational instruction and data reads
  always @(pc or dmem_addr or mem_gen) begin
    insn      = fetch(pc);
    load_data = read_data(dmem_addr);
  end

  // runs at each rising edge, on the values of the cycle that ends there
  task automatic check_cycle();
    word_t mask;
    checks++;
    if (first) begin
      reset_state_a: assert (pc == reset_pc && store_we == '0) else begin
        errors++;
        $display("FAIL pc/store_we: got %h/%h, expected %h/0", pc, store_we, reset_pc);
      end
      first = 1'b0;
    end else begin
      next_pc_a: assert (pc == want_pc) else begin
        errors++;
        $display("FAIL pc: got %h, expected %h", pc, want_pc);
      end
    end
    if (!next_exp.exists(pc)) begin
      errors++;
      $display("pc %h ran outside the test program", pc);
      done = 1'b1;
      return;
    end
    want_pc = next_exp[pc];
    halt_a: assert (halt == (insn == ecall_insn)) else begin
      errors++;
      $display("FAIL halt: got %h, expected %h (insn %h)", halt, insn == ecall_insn, insn);
    end
    if (store_we != '0) begin
      if (exp_addr_q.size() == 0) begin
        errors++;
        $display("store at %h that no test expected", dmem_addr);
      end else begin
        mask = {{8{exp_be_q[0][3]}}, {8{exp_be_q[0][2]}}, {8{exp_be_q[0][1]}},
                {8{exp_be_q[0][0]}}};
        store_addr_a: assert (dmem_addr == exp_addr_q[0]) else begin
          errors++;
          $display("FAIL dmem_addr: got %h, expected %h", dmem_addr, exp_addr_q[0]);
        end
        store_we_a: assert (store_we == exp_be_q[0]) else begin
          errors++;
          $display("FAIL store_we: got %h, expected %h", store_we, exp_be_q[0]);
        end
        store_data_a: assert ((store_data & mask) == (exp_data_q[0] & mask)) else begin
          errors++;
          $display("FAIL store_data: got %h, expected %h", store_data & mask,
                   exp_data_q[0] & mask);
        end
        void'(exp_addr_q.pop_front());
        void'(exp_be_q.pop_front());
        void'(exp_data_q.pop_front());
      end
      dmem[dmem_addr] = merge_bytes(read_data(dmem_addr), store_data, store_we);
      mem_gen <= mem_gen + 1;   // load_data follows after the edge
    end
    if (halt) done = 1'b1;
  endtask

  initial begin
    void'($urandom(6645));
    build_program();
    limit = 2 * prog_len + 50;
    repeat (5) @(posedge clk);
    rst     <= 1'b0;
    mem_gen <= mem_gen + 1;   // first fetch of the loaded program
    while (!done) begin
      @(posedge clk);
      cycles++;
      check_cycle();
    end
    checks++;
    stores_seen_a: assert (exp_addr_q.size() == 0) else begin
      errors++;
      $display("%0d expected stores never happened", exp_addr_q.size());
    end
    $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    wait (limit > 0 && cycles > limit);
    $display("checks %0d, errors %0d, cycles %0d, no halt within %0d cycles",
             checks, errors, cycles, limit);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
